// ==== ce_pkg.sv ====
// Compute element shared definitions
//
// Width defaults for the top level and the opcode constants for both
// stages. Stage 1 picks between add, multiply, fused multiply-add, min and
// max. Stage 2 either passes the stage 1 result on or compares it with the
// delayed bias.

package ce_pkg;

  // Default operand and result width
  localparam int unsigned DATA_W_DEF = 16;

  // Default tag width
  localparam int unsigned TAG_W_DEF = 4;

  // Default depth of the stage 1 register chain
  localparam int unsigned PIPE_DEF = 2;

  // Stage 1 operation codes where 5 to 7 are illegal
  localparam int unsigned OP1_W = 3;

  localparam logic [OP1_W-1:0] OP1_ADD   = 3'd0;
  localparam logic [OP1_W-1:0] OP1_MUL   = 3'd1;
  localparam logic [OP1_W-1:0] OP1_FMADD = 3'd2;
  localparam logic [OP1_W-1:0] OP1_MIN   = 3'd3;
  localparam logic [OP1_W-1:0] OP1_MAX   = 3'd4;

  // Stage 2 operation codes where 3 is illegal
  localparam int unsigned OP2_W = 2;

  localparam logic [OP2_W-1:0] OP2_NONE = 2'd0;
  localparam logic [OP2_W-1:0] OP2_MIN  = 2'd1;
  localparam logic [OP2_W-1:0] OP2_MAX  = 2'd2;

endpackage

// ==== ce_if.sv ====
// Compute element inter-stage interfaces
//
// ce_issue_if carries a decoded operation from decode to the stage 1
// datapath. ce_stage1_if carries the stage 1 result, its tag, the delayed
// bias and the stage 2 code on to the result stage.

`timescale 1ns/1ps

interface ce_issue_if #(
  parameter int unsigned DATA_W = ce_pkg::DATA_W_DEF,
  parameter int unsigned TAG_W  = ce_pkg::TAG_W_DEF
);
  import ce_pkg::*;

  logic              valid;
  logic [TAG_W-1:0]  tag;
  // Multiply-add operands, already muxed per op1
  logic [DATA_W-1:0] mul_a;
  logic [DATA_W-1:0] mul_b;
  logic [DATA_W-1:0] addend;
  // Stage 1 min/max control
  logic              use_minmax;
  logic              max_sel;
  logic [OP2_W-1:0]  op2;
  logic [DATA_W-1:0] y;

  modport src (output valid, tag, mul_a, mul_b, addend, use_minmax, max_sel, op2, y);
  modport dst (input  valid, tag, mul_a, mul_b, addend, use_minmax, max_sel, op2, y);

endinterface

interface ce_stage1_if #(
  parameter int unsigned DATA_W = ce_pkg::DATA_W_DEF,
  parameter int unsigned TAG_W  = ce_pkg::TAG_W_DEF
);
  import ce_pkg::*;

  logic              valid;
  logic [TAG_W-1:0]  tag;
  logic [DATA_W-1:0] res;
  // Bias delayed to line up with res
  logic [DATA_W-1:0] y_dly;
  logic [OP2_W-1:0]  op2;

  modport src (output valid, tag, res, y_dly, op2);
  modport dst (input  valid, tag, res, y_dly, op2);

endinterface

// ==== ce_decode.sv ====
// Compute element decode stage
//
// Accepts an operation on the input handshake, maps op1 onto the shared
// multiply-add datapath or the min/max path, sanitizes op2, and registers
// everything into the issue interface when the pipeline advances.

`timescale 1ns/1ps

module ce_decode #(
  parameter int unsigned DATA_W = 16,
  parameter int unsigned TAG_W  = 4
) (
  input  logic                     stage2_noncomp_input_pipe_clk,
  input  logic                     rst_ni,
  input  logic [DATA_W-1:0]        x_i,
  input  logic [DATA_W-1:0]        w_i,
  input  logic [DATA_W-1:0]        y_i,
  input  logic [ce_pkg::OP1_W-1:0] op1_i,
  input  logic [ce_pkg::OP2_W-1:0] op2_i,
  input  logic [TAG_W-1:0]         tag_i,
  input  logic                     in_valid_i,
  input  logic                     advance_i,
  output logic                     in_ready_o,
  ce_issue_if.src                  issue_o
);
  import ce_pkg::*;

  logic [DATA_W-1:0] mul_b_d;
  logic [DATA_W-1:0] addend_d;
  logic              use_minmax_d;
  logic              max_sel_d;
  logic [OP2_W-1:0]  op2_d;

  // Nothing is taken while the output is stalled
  assign in_ready_o = advance_i;

  always_comb begin
    mul_b_d      = w_i;
    addend_d     = '0;
    use_minmax_d = 1'b0;
    max_sel_d    = 1'b0;
    case (op1_i)
      OP1_MUL:   addend_d = '0;
      OP1_FMADD: addend_d = y_i;
      OP1_MIN:   use_minmax_d = 1'b1;
      OP1_MAX: begin
        use_minmax_d = 1'b1;
        max_sel_d    = 1'b1;
      end
      // ADD and illegal codes compute x*1 + w
      default: begin
        mul_b_d  = DATA_W'(1);
        addend_d = w_i;
      end
    endcase
    // FMADD never goes through stage 2
    op2_d = (op1_i == OP1_FMADD || op2_i > OP2_MAX) ? OP2_NONE : op2_i;
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_o.valid <= 1'b0;
    end else if (advance_i) begin
      issue_o.valid <= in_valid_i;
    end
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk) begin
    if (advance_i) begin
      issue_o.tag        <= tag_i;
      issue_o.mul_a      <= x_i;
      issue_o.mul_b      <= mul_b_d;
      issue_o.addend     <= addend_d;
      issue_o.use_minmax <= use_minmax_d;
      issue_o.max_sel    <= max_sel_d;
      issue_o.op2        <= op2_d;
      issue_o.y          <= y_i;
    end
  end

  // Accepted operations carry only legal opcodes
  a_legal_opcodes: assert property (
    @(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    (in_valid_i && in_ready_o) |-> (op1_i <= OP1_MAX && op2_i <= OP2_MAX)
  ) else $error("illegal opcode accepted: op1=%0d op2=%0d", op1_i, op2_i);

endmodule

// ==== ce_mac_stage.sv ====
// Compute element stage 1
//
// Computes mul_a*mul_b+addend modulo 2^DATA_W, or the signed min/max of
// mul_a and mul_b, then passes the result through NUM_PIPE_REGS registers.
// Valid, tag, op2 and the bias travel in a parallel chain of equal depth so
// that stage 2 sees them aligned with the result.

`timescale 1ns/1ps

module ce_mac_stage #(
  parameter int unsigned DATA_W        = 16,
  parameter int unsigned TAG_W         = 4,
  parameter int unsigned NUM_PIPE_REGS = 2
) (
  input  logic     stage2_noncomp_input_pipe_clk,
  input  logic     rst_ni,
  input  logic     advance_i,
  ce_issue_if.dst  issue_i,
  ce_stage1_if.src s1_o
);
  import ce_pkg::*;

  logic [DATA_W-1:0]        mac_res;
  logic [DATA_W-1:0]        minmax_res;
  logic [DATA_W-1:0]        stage_res;
  logic                     a_lt_b;

  logic [NUM_PIPE_REGS-1:0] valid_q;
  logic [TAG_W-1:0]         tag_q   [NUM_PIPE_REGS];
  logic [DATA_W-1:0]        res_q   [NUM_PIPE_REGS];
  logic [DATA_W-1:0]        y_q     [NUM_PIPE_REGS];
  logic [OP2_W-1:0]         op2_q   [NUM_PIPE_REGS];

  // Only the low DATA_W bits of the product survive
  assign mac_res = issue_i.mul_a * issue_i.mul_b + issue_i.addend;

  assign a_lt_b = $signed(issue_i.mul_a) < $signed(issue_i.mul_b);

  always_comb begin
    if (issue_i.max_sel) begin
      minmax_res = a_lt_b ? issue_i.mul_b : issue_i.mul_a;
    end else begin
      minmax_res = a_lt_b ? issue_i.mul_a : issue_i.mul_b;
    end
  end

  assign stage_res = issue_i.use_minmax ? minmax_res : mac_res;

  // Valid chain
  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance_i) begin
      valid_q[0] <= issue_i.valid;
      for (int i = 1; i < NUM_PIPE_REGS; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk) begin
    if (advance_i) begin
      res_q[0] <= stage_res;
      tag_q[0] <= issue_i.tag;
      y_q[0]   <= issue_i.y;
      op2_q[0] <= issue_i.op2;
      for (int i = 1; i < NUM_PIPE_REGS; i++) begin
        res_q[i] <= res_q[i-1];
        tag_q[i] <= tag_q[i-1];
        y_q[i]   <= y_q[i-1];
        op2_q[i] <= op2_q[i-1];
      end
    end
  end

  assign s1_o.valid = valid_q[NUM_PIPE_REGS-1];
  assign s1_o.tag   = tag_q[NUM_PIPE_REGS-1];
  assign s1_o.res   = res_q[NUM_PIPE_REGS-1];
  assign s1_o.y_dly = y_q[NUM_PIPE_REGS-1];
  assign s1_o.op2   = op2_q[NUM_PIPE_REGS-1];

  // Valid bits on both sides of this stage are known once out of reset
  a_valid_known: assert property (
    @(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    !$isunknown({issue_i.valid, s1_o.valid})
  ) else $error("unknown valid in stage 1");

endmodule

// ==== ce_result.sv ====
// Compute element stage 2 and output register
//
// Applies op2 to the stage 1 result: pass it on, or take the signed min or
// max against the delayed bias. The outcome lands in the output register,
// which also decides when the whole pipeline may advance.

`timescale 1ns/1ps

module ce_result #(
  parameter int unsigned DATA_W = 16,
  parameter int unsigned TAG_W  = 4
) (
  input  logic              stage2_noncomp_input_pipe_clk,
  input  logic              rst_ni,
  ce_stage1_if.dst          s1_i,
  input  logic              out_ready_i,
  output logic              advance_o,
  output logic [DATA_W-1:0] z_o,
  output logic [TAG_W-1:0]  tag_o,
  output logic              out_valid_o
);
  import ce_pkg::*;

  logic [DATA_W-1:0] stage2_res;
  logic              res_lt_y;

  // Move on when the output slot is empty or being drained
  assign advance_o = !out_valid_o || out_ready_i;

  assign res_lt_y = $signed(s1_i.res) < $signed(s1_i.y_dly);

  always_comb begin
    case (s1_i.op2)
      OP2_MIN: stage2_res = res_lt_y ? s1_i.res : s1_i.y_dly;
      OP2_MAX: stage2_res = res_lt_y ? s1_i.y_dly : s1_i.res;
      default: stage2_res = s1_i.res;
    endcase
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (advance_o) begin
      out_valid_o <= s1_i.valid;
    end
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk) begin
    if (advance_o) begin
      z_o   <= stage2_res;
      tag_o <= s1_i.tag;
    end
  end

  // A stalled result stays put until it is taken
  a_stall_stable: assert property (
    @(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(z_o) && $stable(tag_o))
  ) else $error("output changed while stalled");

endmodule

// ==== compute_element.sv ====
// Two-stage integer compute element
//
// Stage 1 does add, multiply, multiply-add, min or max on x and w with
// bias y. Stage 2 optionally takes min or max against a delayed y.
// Valid/ready handshakes on both sides; a stalled output freezes the
// whole pipeline.

`timescale 1ns/1ps

module compute_element #(
  parameter int unsigned DATA_W        = ce_pkg::DATA_W_DEF,
  parameter int unsigned TAG_W         = ce_pkg::TAG_W_DEF,
  parameter int unsigned NUM_PIPE_REGS = ce_pkg::PIPE_DEF
) (
  input  logic                     stage2_noncomp_input_pipe_clk,
  input  logic                     rst_ni,
  input  logic [DATA_W-1:0]        x_i,
  input  logic [DATA_W-1:0]        w_i,
  input  logic [DATA_W-1:0]        y_i,
  input  logic [ce_pkg::OP1_W-1:0] op1_i,
  input  logic [ce_pkg::OP2_W-1:0] op2_i,
  input  logic [TAG_W-1:0]         tag_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output logic [DATA_W-1:0]        z_o,
  output logic [TAG_W-1:0]         tag_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  logic advance;

  ce_issue_if  #(.DATA_W(DATA_W), .TAG_W(TAG_W)) issue_if ();
  ce_stage1_if #(.DATA_W(DATA_W), .TAG_W(TAG_W)) stage1_if ();

  ce_decode #(
    .DATA_W (DATA_W),
    .TAG_W  (TAG_W)
  ) i_decode (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .x_i                           (x_i),
    .w_i                           (w_i),
    .y_i                           (y_i),
    .op1_i                         (op1_i),
    .op2_i                         (op2_i),
    .tag_i                         (tag_i),
    .in_valid_i                    (in_valid_i),
    .advance_i                     (advance),
    .in_ready_o                    (in_ready_o),
    .issue_o                       (issue_if.src)
  );

  ce_mac_stage #(
    .DATA_W        (DATA_W),
    .TAG_W         (TAG_W),
    .NUM_PIPE_REGS (NUM_PIPE_REGS)
  ) i_mac_stage (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .advance_i                     (advance),
    .issue_i                       (issue_if.dst),
    .s1_o                          (stage1_if.src)
  );

  ce_result #(
    .DATA_W (DATA_W),
    .TAG_W  (TAG_W)
  ) i_result (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .s1_i                          (stage1_if.dst),
    .out_ready_i                   (out_ready_i),
    .advance_o                     (advance),
    .z_o                           (z_o),
    .tag_o                         (tag_o),
    .out_valid_o                   (out_valid_o)
  );

endmodule

// ==== tb_compute_element.sv ====
// Testbench for the two-stage integer compute element
//
// Random legal operations with extreme operands go in under random
// valid/ready traffic. A model built from the stage 1 and stage 2 rules
// predicts each result, and a queue checks order, tags and values. Short
// directed phases cover reset state, first-result latency and stall fill.

`timescale 1ns/1ps

module tb_compute_element;
  import ce_pkg::*;

  localparam int unsigned DATA_W        = DATA_W_DEF;
  localparam int unsigned TAG_W         = TAG_W_DEF;
  localparam int unsigned NUM_PIPE_REGS = PIPE_DEF;

  localparam int NUM_INPUTS   = 2000;
  localparam int LAT_ITEMS    = 4;
  localparam int STALL_CYCLES = 10;
  localparam int DRAIN_CYCLES = 4 * (NUM_PIPE_REGS + 2);
  // About 1.8 cycles per random input at 75% valid and 75% ready,
  // so four per input leaves room for reset and the directed phases
  localparam int TIMEOUT_CYCLES = 4 * NUM_INPUTS;

  logic              stage2_noncomp_input_pipe_clk;
  logic              rst_ni;
  logic [DATA_W-1:0] x_i;
  logic [DATA_W-1:0] w_i;
  logic [DATA_W-1:0] y_i;
  logic [OP1_W-1:0]  op1_i;
  logic [OP2_W-1:0]  op2_i;
  logic [TAG_W-1:0]  tag_i;
  logic              in_valid_i;
  logic              in_ready_o;
  logic [DATA_W-1:0] z_o;
  logic [TAG_W-1:0]  tag_o;
  logic              out_valid_o;
  logic              out_ready_i;

  integer            seed;
  int                errors;
  int                checked;
  int                accepted;
  int                cycle;
  int                first_acc_cycle;
  int                first_out_cycle;
  int                target;
  int                stall_start;
  logic              in_taken;
  logic              hold_pending;
  logic [DATA_W-1:0] held_z;
  logic [TAG_W-1:0]  held_tag;
  logic [DATA_W-1:0] exp_z_q[$];
  logic [TAG_W-1:0]  exp_tag_q[$];

  compute_element #(
    .DATA_W        (DATA_W),
    .TAG_W         (TAG_W),
    .NUM_PIPE_REGS (NUM_PIPE_REGS)
  ) i_compute_element (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .x_i                           (x_i),
    .w_i                           (w_i),
    .y_i                           (y_i),
    .op1_i                         (op1_i),
    .op2_i                         (op2_i),
    .tag_i                         (tag_i),
    .in_valid_i                    (in_valid_i),
    .in_ready_o                    (in_ready_o),
    .z_o                           (z_o),
    .tag_o                         (tag_o),
    .out_valid_o                   (out_valid_o),
    .out_ready_i                   (out_ready_i)
  );

  always #50 stage2_noncomp_input_pipe_clk = ~stage2_noncomp_input_pipe_clk;

  // Expected z, with wrapping arithmetic and signed compares
  function automatic logic [DATA_W-1:0] model_z(input logic [OP1_W-1:0] op1,
                                                input logic [OP2_W-1:0] op2,
                                                input logic [DATA_W-1:0] x, w, y);
    logic [DATA_W-1:0] s1;
    logic [DATA_W-1:0] s2;
    case (op1)
      OP1_ADD:   s1 = x + w;
      OP1_MUL:   s1 = x * w;
      OP1_FMADD: s1 = x * w + y;
      OP1_MIN:   s1 = ($signed(x) < $signed(w)) ? x : w;
      // MAX is the only legal code left
      default:   s1 = ($signed(x) > $signed(w)) ? x : w;
    endcase
    if (op1 == OP1_FMADD || op2 == OP2_NONE) begin
      s2 = s1;
    end else if (op2 == OP2_MIN) begin
      s2 = ($signed(s1) < $signed(y)) ? s1 : y;
    end else begin
      s2 = ($signed(s1) > $signed(y)) ? s1 : y;
    end
    return s2;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  // Extremes show up often so that sign boundaries get crossed
  task automatic pick_operand(output logic [DATA_W-1:0] v);
    int sel;
    sel = $random(seed) & 7;
    case (sel)
      0: begin
        v = '0;
        v[DATA_W-1] = 1'b1;
      end
      1: begin
        v = '1;
        v[DATA_W-1] = 1'b0;
      end
      2: v = '0;
      3: v = '1;
      4: v = DATA_W'(1);
      default: v = DATA_W'($random(seed));
    endcase
  endtask

  task automatic load_random_item();
    op1_i = OP1_W'({$random(seed)} % 5);
    op2_i = OP2_W'({$random(seed)} % 3);
    tag_i = TAG_W'($random(seed));
    pick_operand(x_i);
    pick_operand(w_i);
    pick_operand(y_i);
  endtask

  // Samples at the falling edge, where inputs and outputs are settled
  task automatic watch_outputs();
    logic [DATA_W-1:0] exp_z;
    logic [TAG_W-1:0]  exp_tag;
    forever begin
      @(negedge stage2_noncomp_input_pipe_clk);
      in_taken = rst_ni && in_valid_i && in_ready_o;
      if (in_taken) begin
        exp_z_q.push_back(model_z(op1_i, op2_i, x_i, w_i, y_i));
        exp_tag_q.push_back(tag_i);
        accepted++;
        if (first_acc_cycle < 0) begin
          first_acc_cycle = cycle;
        end
      end
      if (rst_ni && out_valid_o && first_out_cycle < 0) begin
        first_out_cycle = cycle;
      end
      if (hold_pending) begin
        check_value("z_o while stalled", 64'(held_z), 64'(z_o));
        check_value("tag_o while stalled", 64'(held_tag), 64'(tag_o));
      end
      hold_pending = rst_ni && out_valid_o && !out_ready_i;
      held_z       = z_o;
      held_tag     = tag_o;
      if (rst_ni && out_valid_o && out_ready_i) begin
        if (exp_z_q.size() == 0) begin
          $display("Error at %0t: a result came out with no input left to match it", $time);
          errors++;
        end else begin
          exp_z   = exp_z_q.pop_front();
          exp_tag = exp_tag_q.pop_front();
          check_value("z_o", 64'(exp_z), 64'(z_o));
          check_value("tag_o", 64'(exp_tag), 64'(tag_o));
          checked++;
        end
      end
    end
  endtask

  task automatic print_summary();
    $display("Errors: %0d, results checked: %0d, inputs accepted: %0d",
             errors, checked, accepted);
  endtask

  task automatic run_watchdog();
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      cycle++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_summary();
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Waits with out_ready_i high until the queue empties and returns 5 ns after an edge
  task automatic drain_outputs();
    int n;
    n = 0;
    while (exp_z_q.size() != 0 && n < DRAIN_CYCLES) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      n++;
    end
    #5;
  endtask

  initial begin
    stage2_noncomp_input_pipe_clk = 1'b0;
    rst_ni          = 1'b0;
    x_i             = '0;
    w_i             = '0;
    y_i             = '0;
    op1_i           = OP1_ADD;
    op2_i           = OP2_NONE;
    tag_i           = '0;
    in_valid_i      = 1'b0;
    out_ready_i     = 1'b0;
    seed            = 37;
    errors          = 0;
    checked         = 0;
    accepted        = 0;
    cycle           = 0;
    first_acc_cycle = -1;
    first_out_cycle = -1;
    in_taken        = 1'b0;
    hold_pending    = 1'b0;
    fork
      watch_outputs();
      run_watchdog();
    join_none

    repeat (16) @(posedge stage2_noncomp_input_pipe_clk);
    #5;
    rst_ni = 1'b1;
    @(posedge stage2_noncomp_input_pipe_clk);
    #5;
    check_value("out_valid_o after reset", 64'd0, 64'(out_valid_o));
    check_value("in_ready_o after reset", 64'd1, 64'(in_ready_o));

    // Back to back inputs into an empty pipeline with the output open
    out_ready_i = 1'b1;
    in_valid_i  = 1'b1;
    repeat (LAT_ITEMS) begin
      load_random_item();
      @(posedge stage2_noncomp_input_pipe_clk);
      #5;
    end
    in_valid_i = 1'b0;
    drain_outputs();
    check_value("first output latency", 64'(NUM_PIPE_REGS + 2),
                64'(first_out_cycle - first_acc_cycle));

    // Output blocked, so the pipeline fills and then refuses input
    out_ready_i = 1'b0;
    in_valid_i  = 1'b1;
    load_random_item();
    stall_start = accepted;
    repeat (STALL_CYCLES) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      #5;
      if (in_taken) begin
        load_random_item();
      end
    end
    check_value("in_ready_o with full pipeline", 64'd0, 64'(in_ready_o));
    check_value("inputs taken while stalled", 64'(NUM_PIPE_REGS + 2),
                64'(accepted - stall_start));
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    drain_outputs();

    // Random traffic where an offered item holds until it is taken
    target = accepted + NUM_INPUTS;
    while (accepted < target) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      #5;
      out_ready_i = (($random(seed) & 3) != 0);
      if (!in_valid_i || in_taken) begin
        if (accepted < target) begin
          in_valid_i = (($random(seed) & 3) != 0);
          load_random_item();
        end else begin
          in_valid_i = 1'b0;
        end
      end
    end
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    drain_outputs();
    repeat (4) @(posedge stage2_noncomp_input_pipe_clk);

    if (exp_z_q.size() != 0) begin
      $display("Error: %0d results were expected but never came out", exp_z_q.size());
      errors++;
    end
    print_summary();
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
ce_pkg.sv
ce_if.sv
ce_decode.sv
ce_mac_stage.sv
ce_result.sv
compute_element.sv
tb_compute_element.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the compute element testbench with Verilator and runs it.
# The run counts as failed if the build or the simulation returns an error,
# or if the simulation log holds the fail message.

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_compute_element
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" -f all.f --Mdir "$BUILD_DIR" -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure, see $LOG"
exit 0
